// ==== fcvt_pkg.sv ====
// Shared definitions: operation codes, operand union, widths, class codes and flag positions.

package fcvt_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int res_width  = 64;  // Integer result, 32-bit results sign-extended.
  localparam int tag_width  = 4;   // Tag carried back with every result.
  localparam int flag_width = 2;
  localparam int exp_width  = 13;  // Signed unbiased exponent, room for both formats.

  // Flag positions inside the flags word.
  localparam int flag_inexact = 0;
  localparam int flag_invalid = 1;

  // Format bit of an operation.
  localparam logic fmt_sng = 1'b0;
  localparam logic fmt_dbl = 1'b1;

  // Operand classes produced by the first stage.
  localparam logic [1:0] cls_zero = 2'd0;  // Zero or denormal.
  localparam logic [1:0] cls_norm = 2'd1;
  localparam logic [1:0] cls_inf  = 2'd2;
  localparam logic [1:0] cls_nan  = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    cvt32 = 2'd0,  // Truncate to signed 32-bit.
    cvt64 = 2'd1,  // Truncate to signed 64-bit.
    raw   = 2'd2   // Pass the operand bits through.
  } fcvt_op_e;

  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] frac;
  } dbl_t;

  // A single sits in the low half of the word.
  typedef struct packed {
    logic [31:0] pad;
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } sng_t;

  typedef union packed {
    dbl_t dbl;
    sng_t sng;
  } fp_word_u;

endpackage

// ==== fcvt_in_fifo.sv ====
// Input operation buffer: circular storage of op, format, operand and tag.

module fcvt_in_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               push,
  input  fcvt_pkg::fcvt_op_e                 push_op,
  input  logic                               push_fmt,
  input  fcvt_pkg::fp_word_u                 push_word,
  input  logic [fcvt_pkg::tag_width-1:0]     push_tag,
  input  logic                               pop,
  output logic                               empty,
  output fcvt_pkg::fcvt_op_e                 head_op,
  output logic                               head_fmt,
  output fcvt_pkg::fp_word_u                 head_word,
  output logic [fcvt_pkg::tag_width-1:0]     head_tag
);

  localparam int ptr_width = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_width = $clog2(DEPTH + 1);

  fcvt_pkg::fcvt_op_e             op_mem   [DEPTH];
  logic                           fmt_mem  [DEPTH];
  fcvt_pkg::fp_word_u             word_mem [DEPTH];
  logic [fcvt_pkg::tag_width-1:0] tag_mem  [DEPTH];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [cnt_width-1:0] count;

  // Storage is written on the edge that samples push.
  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr]   <= push_op;
      fmt_mem[wr_ptr]  <= push_fmt;
      word_mem[wr_ptr] <= push_word;
      tag_mem[wr_ptr]  <= push_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_width'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap for any depth.
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_width'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  assign empty     = (count == '0);
  assign head_op   = op_mem[rd_ptr];  // Head is visible before the pop.
  assign head_fmt  = fmt_mem[rd_ptr];
  assign head_word = word_mem[rd_ptr];
  assign head_tag  = tag_mem[rd_ptr];

endmodule

// ==== fcvt_classify.sv ====
// First pipeline stage: operand decode, classification, bias removal and significand alignment.

module fcvt_classify (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  load,
  input  logic                                  advance,
  input  fcvt_pkg::fcvt_op_e                    in_op,
  input  logic                                  in_fmt,
  input  fcvt_pkg::fp_word_u                    in_word,
  input  logic [fcvt_pkg::tag_width-1:0]        in_tag,
  output logic                                  valid,
  output fcvt_pkg::fcvt_op_e                    out_op,
  output logic                                  out_sign,
  output logic [63:0]                           out_mant,
  output logic signed [fcvt_pkg::exp_width-1:0] out_exp,
  output logic [1:0]                            out_class,
  output logic                                  out_is64,
  output fcvt_pkg::fp_word_u                    out_word,
  output logic [fcvt_pkg::tag_width-1:0]        out_tag
);

  logic                                  sign_d;
  logic                                  exp_zero;
  logic                                  exp_max;
  logic                                  frac_nz;
  logic signed [fcvt_pkg::exp_width-1:0] exp_d;
  logic [63:0]                           mant_d;
  logic [1:0]                            class_d;

  //////////////////////////////////////////////////////////////////////
  // Decode through the union member selected by the format bit
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (in_fmt == fcvt_pkg::fmt_dbl) begin
      sign_d   = in_word.dbl.sign;
      exp_zero = (in_word.dbl.exp == '0);
      exp_max  = &in_word.dbl.exp;
      frac_nz  = |in_word.dbl.frac;
      exp_d    = $signed({2'b00, in_word.dbl.exp}) - 13'sd1023;
      mant_d   = {~exp_zero, in_word.dbl.frac, 11'b0};  // Hidden bit lands on bit 63.
    end else begin
      sign_d   = in_word.sng.sign;
      exp_zero = (in_word.sng.exp == '0);
      exp_max  = &in_word.sng.exp;
      frac_nz  = |in_word.sng.frac;
      exp_d    = $signed({5'b00000, in_word.sng.exp}) - 13'sd127;
      mant_d   = {~exp_zero, in_word.sng.frac, 40'b0};
    end

    // A denormal keeps its fraction bits so stage 2 can flag inexact.
    if (exp_zero) begin
      class_d = fcvt_pkg::cls_zero;
    end else if (exp_max) begin
      class_d = frac_nz ? fcvt_pkg::cls_nan : fcvt_pkg::cls_inf;
    end else begin
      class_d = fcvt_pkg::cls_norm;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (advance) begin
      valid <= 1'b0;  // Entry taken by stage 2 and nothing new behind it.
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_op    <= in_op;
      out_sign  <= sign_d;
      out_mant  <= mant_d;
      out_exp   <= exp_d;
      out_class <= class_d;
      out_is64  <= (in_op == fcvt_pkg::cvt64);
      out_word  <= in_word;
      out_tag   <= in_tag;
    end
  end

endmodule

// ==== fcvt_shift_sat.sv ====
// Second pipeline stage: shift, truncate, negate, saturate, flag generation and result hold.

module fcvt_shift_sat (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  load,
  input  logic                                  fire,
  input  fcvt_pkg::fcvt_op_e                    in_op,
  input  logic                                  in_sign,
  input  logic [63:0]                           in_mant,
  input  logic signed [fcvt_pkg::exp_width-1:0] in_exp,
  input  logic [1:0]                            in_class,
  input  logic                                  in_is64,
  input  fcvt_pkg::fp_word_u                    in_word,
  input  logic [fcvt_pkg::tag_width-1:0]        in_tag,
  output logic                                  valid,
  output logic [fcvt_pkg::res_width-1:0]        res_value,
  output logic [fcvt_pkg::flag_width-1:0]       res_flags,
  output logic [fcvt_pkg::tag_width-1:0]        res_tag
);

  logic signed [fcvt_pkg::exp_width-1:0] shamt_wide;
  logic [5:0]                            shamt;
  logic [63:0]                           mag;
  logic                                  lost;
  logic                                  ovf;
  logic [63:0]                           pos_max;
  logic [63:0]                           neg_min;
  logic [63:0]                           limit;
  logic [fcvt_pkg::res_width-1:0]        value_d;
  logic [fcvt_pkg::flag_width-1:0]       flags_d;

  always_comb begin
    // The binary point sits below bit 63 - exp of the aligned significand.
    shamt_wide = 13'sd63 - in_exp;
    shamt      = shamt_wide[5:0];
    mag        = in_mant >> shamt;
    lost       = |(in_mant & ~({64{1'b1}} << shamt));
    if (in_exp[fcvt_pkg::exp_width-1]) begin
      mag  = '0;  // Magnitude below one truncates to zero.
      lost = |in_mant;
    end

    if (in_is64) begin
      pos_max = 64'h7fff_ffff_ffff_ffff;
      neg_min = 64'h8000_0000_0000_0000;
      limit   = 64'h8000_0000_0000_0000;
    end else begin
      pos_max = 64'h0000_0000_7fff_ffff;
      neg_min = 64'hffff_ffff_8000_0000;  // Sign-extended int32 minimum.
      limit   = 64'h0000_0000_8000_0000;
    end

    // Negative side reaches one step further than the positive side.
    ovf = (in_exp > 13'sd63) || (in_sign ? (mag > limit) : (mag >= limit));

    value_d = '0;
    flags_d = '0;
    case (in_class)
      fcvt_pkg::cls_nan: begin
        value_d                       = pos_max;
        flags_d[fcvt_pkg::flag_invalid] = 1'b1;
      end
      fcvt_pkg::cls_inf: begin
        value_d                       = in_sign ? neg_min : pos_max;
        flags_d[fcvt_pkg::flag_invalid] = 1'b1;
      end
      fcvt_pkg::cls_zero: begin
        flags_d[fcvt_pkg::flag_inexact] = |in_mant;  // Nonzero denormal.
      end
      default: begin
        if (ovf) begin
          value_d                       = in_sign ? neg_min : pos_max;
          flags_d[fcvt_pkg::flag_invalid] = 1'b1;
        end else begin
          value_d                       = in_sign ? -mag : mag;
          flags_d[fcvt_pkg::flag_inexact] = lost;
        end
      end
    endcase

    if (in_op == fcvt_pkg::raw) begin
      value_d = in_word;
      flags_d = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;  // A load in the firing cycle keeps the stage full.
    end else if (fire) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      res_value <= value_d;
      res_flags <= flags_d;
      res_tag   <= in_tag;
    end
  end

endmodule

// ==== fcvt_credit_counter.sv ====
// Result credit counter: credits granted by the consumer minus results sent.

module fcvt_credit_counter #(
  parameter int RES_CREDITS = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic credit_in,
  input  logic spend,
  output logic credit_avail
);

  localparam int cnt_width = $clog2(RES_CREDITS + 1);

  logic [cnt_width-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (credit_in && !spend) begin
      if (count != cnt_width'(RES_CREDITS)) begin
        count <= count + 1'b1;  // Held at the ceiling.
      end
    end else if (spend && !credit_in) begin
      count <= count - 1'b1;
    end
    // Grant and spend together leave the count unchanged.
  end

  assign credit_avail = (count != '0);

endmodule

// ==== fcvt_seq.sv ====
// Sequencer FSM: initial input credit grant, buffer pop, pipeline advance and credit return.

module fcvt_seq #(
  parameter int DEPTH = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic fifo_empty,
  input  logic stage1_valid,
  input  logic stage2_valid,
  input  logic credit_avail,
  output logic in_credit,
  output logic fifo_pop,
  output logic stage1_load,
  output logic stage1_advance,
  output logic stage2_load,
  output logic res_fire
);

  localparam int cnt_width = $clog2(DEPTH + 1);

  typedef enum logic [1:0] {
    st_grant,
    st_run,
    st_stall
  } state_e;

  state_e               state;
  logic [cnt_width-1:0] grant_cnt;
  logic                 active;

  //////////////////////////////////////////////////////////////////////
  // Advance chain, evaluated from the back of the pipeline forward
  //////////////////////////////////////////////////////////////////////

  assign active         = (state != st_grant);
  assign res_fire       = active && stage2_valid && credit_avail;
  assign stage2_load    = active && stage1_valid && (!stage2_valid || res_fire);
  assign stage1_advance = stage2_load;
  assign stage1_load    = active && !fifo_empty && (!stage1_valid || stage1_advance);
  assign fifo_pop       = stage1_load;  // Buffer head moves exactly when stage 1 takes it.

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_grant;
      grant_cnt <= '0;
      in_credit <= 1'b0;
    end else begin
      case (state)
        st_grant: begin
          in_credit <= 1'b1;  // One credit per buffer entry.
          grant_cnt <= grant_cnt + 1'b1;
          if (grant_cnt == cnt_width'(DEPTH - 1)) begin
            state <= st_run;
          end
        end
        st_run, st_stall: begin
          in_credit <= fifo_pop;  // A freed entry goes back to the producer.
          state     <= (stage2_valid && !credit_avail) ? st_stall : st_run;
        end
        default: begin
          in_credit <= 1'b0;
          state     <= st_grant;
        end
      endcase
    end
  end

endmodule

// ==== fcvt_top.sv ====
// Converter top level: input buffer, two pipeline stages, result credit counter and sequencer.

module fcvt_top #(
  parameter int DEPTH       = 4,
  parameter int RES_CREDITS = 4
) (
  input  logic                              clk,
  input  logic                              reset,
  // Producer side.
  input  logic                              in_valid,
  input  fcvt_pkg::fcvt_op_e                in_op,
  input  logic                              in_fmt,
  input  fcvt_pkg::fp_word_u                in_word,
  input  logic [fcvt_pkg::tag_width-1:0]    in_tag,
  output logic                              in_credit,
  // Consumer side.
  input  logic                              res_credit,
  output logic                              res_valid,
  output logic [fcvt_pkg::res_width-1:0]    res_value,
  output logic [fcvt_pkg::flag_width-1:0]   res_flags,
  output logic [fcvt_pkg::tag_width-1:0]    res_tag
);

  logic                                  fifo_empty;
  logic                                  fifo_pop;
  fcvt_pkg::fcvt_op_e                    head_op;
  logic                                  head_fmt;
  fcvt_pkg::fp_word_u                    head_word;
  logic [fcvt_pkg::tag_width-1:0]        head_tag;

  logic                                  stage1_load;
  logic                                  stage1_advance;
  logic                                  stage1_valid;
  fcvt_pkg::fcvt_op_e                    s1_op;
  logic                                  s1_sign;
  logic [63:0]                           s1_mant;
  logic signed [fcvt_pkg::exp_width-1:0] s1_exp;
  logic [1:0]                            s1_class;
  logic                                  s1_is64;
  fcvt_pkg::fp_word_u                    s1_word;
  logic [fcvt_pkg::tag_width-1:0]        s1_tag;

  logic                                  stage2_load;
  logic                                  stage2_valid;
  logic                                  credit_avail;
  logic                                  res_fire;

  fcvt_in_fifo #(.DEPTH(DEPTH)) i_in_fifo (
    .clk(clk), .reset(reset), .push(in_valid), .push_op(in_op), .push_fmt(in_fmt),
    .push_word(in_word), .push_tag(in_tag), .pop(fifo_pop), .empty(fifo_empty),
    .head_op(head_op), .head_fmt(head_fmt), .head_word(head_word), .head_tag(head_tag)
  );

  fcvt_classify i_classify (
    .clk(clk), .reset(reset), .load(stage1_load), .advance(stage1_advance),
    .in_op(head_op), .in_fmt(head_fmt), .in_word(head_word), .in_tag(head_tag),
    .valid(stage1_valid), .out_op(s1_op), .out_sign(s1_sign), .out_mant(s1_mant),
    .out_exp(s1_exp), .out_class(s1_class), .out_is64(s1_is64), .out_word(s1_word),
    .out_tag(s1_tag)
  );

  fcvt_shift_sat i_shift_sat (
    .clk(clk), .reset(reset), .load(stage2_load), .fire(res_fire), .in_op(s1_op),
    .in_sign(s1_sign), .in_mant(s1_mant), .in_exp(s1_exp), .in_class(s1_class),
    .in_is64(s1_is64), .in_word(s1_word), .in_tag(s1_tag), .valid(stage2_valid),
    .res_value(res_value), .res_flags(res_flags), .res_tag(res_tag)
  );

  fcvt_credit_counter #(.RES_CREDITS(RES_CREDITS)) i_credit_counter (
    .clk(clk), .reset(reset), .credit_in(res_credit), .spend(res_fire),
    .credit_avail(credit_avail)
  );

  fcvt_seq #(.DEPTH(DEPTH)) i_seq (
    .clk(clk), .reset(reset), .fifo_empty(fifo_empty), .stage1_valid(stage1_valid),
    .stage2_valid(stage2_valid), .credit_avail(credit_avail), .in_credit(in_credit),
    .fifo_pop(fifo_pop), .stage1_load(stage1_load), .stage1_advance(stage1_advance),
    .stage2_load(stage2_load), .res_fire(res_fire)
  );

  assign res_valid = res_fire;  // One pulse per result sent against a credit.

endmodule

// ==== tb_fcvt_top.sv ====
// Testbench for fcvt_top: reference converter, LFSR stimulus, credit producer, consumer, compare.

module tb_fcvt_top;

  localparam int depth       = 4;
  localparam int res_credits = 4;
  localparam int n_rand      = 48;
  localparam int n_special   = 44;  // Eleven operands, two formats, two widths.
  localparam int n_raw       = 16;
  localparam int n_bp        = 16;
  localparam int total_ops   = 2 * n_rand + n_special + n_raw + n_bp;
  localparam int pol_hold    = 0;
  localparam int pol_free    = 1;
  localparam int pol_single  = 2;

  logic                             clk;
  logic                             reset;
  logic                             in_valid;
  fcvt_pkg::fcvt_op_e               in_op;
  logic                             in_fmt;
  fcvt_pkg::fp_word_u               in_word;
  logic [fcvt_pkg::tag_width-1:0]   in_tag;
  logic                             in_credit;
  logic                             res_credit;
  logic                             res_valid;
  logic [fcvt_pkg::res_width-1:0]   res_value;
  logic [fcvt_pkg::flag_width-1:0]  res_flags;
  logic [fcvt_pkg::tag_width-1:0]   res_tag;

  fcvt_pkg::fcvt_op_e             send_op[$];
  logic                           send_fmt[$];
  logic [63:0]                    send_word[$];
  logic [63:0]                    exp_value[$];
  logic [1:0]                     exp_flags[$];
  logic [fcvt_pkg::tag_width-1:0] exp_tag[$];

  string                          test_name;
  int                             policy;
  logic [31:0]                    lfsr_state;
  logic [fcvt_pkg::tag_width-1:0] next_tag;
  logic [65:0]                    ref_res;
  logic [63:0]                    want_value;
  logic [1:0]                     want_flags;
  logic [fcvt_pkg::tag_width-1:0] want_tag;
  int credits, ops_sent, res_granted, results_seen, credit_issued, res_taken;
  int value_errors, flag_errors, tag_errors, protocol_errors;

  fcvt_top #(.DEPTH(depth), .RES_CREDITS(res_credits)) i_fcvt_top (
    .clk(clk), .reset(reset), .in_valid(in_valid), .in_op(in_op), .in_fmt(in_fmt),
    .in_word(in_word), .in_tag(in_tag), .in_credit(in_credit), .res_credit(res_credit),
    .res_valid(res_valid), .res_value(res_value), .res_flags(res_flags), .res_tag(res_tag)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model and stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Truncating conversion with saturation, following the IEEE field layout directly.
  function automatic logic [65:0] fcvt_ref(fcvt_pkg::fcvt_op_e op, logic fmt, logic [63:0] word);
    logic         sign;
    logic         exp_zero;
    logic         exp_max;
    logic         frac_nz;
    int           e;
    int           fbits;
    logic [127:0] m;
    logic [127:0] mag;
    logic [127:0] lim;
    logic         lost;
    logic [63:0]  pmax;
    logic [63:0]  nmin;
    logic [1:0]   inv;
    logic [1:0]   inx;
    inv = '0;
    inx = '0;
    inv[fcvt_pkg::flag_invalid] = 1'b1;
    inx[fcvt_pkg::flag_inexact] = 1'b1;
    if (fmt == fcvt_pkg::fmt_dbl) begin
      sign     = word[63];
      exp_zero = (word[62:52] == '0);
      exp_max  = &word[62:52];
      frac_nz  = |word[51:0];
      e        = int'(word[62:52]) - 1023;
      fbits    = 52;
      m        = {75'b0, 1'b1, word[51:0]};
    end else begin
      sign     = word[31];
      exp_zero = (word[30:23] == '0);
      exp_max  = &word[30:23];
      frac_nz  = |word[22:0];
      e        = int'(word[30:23]) - 127;
      fbits    = 23;
      m        = {104'b0, 1'b1, word[22:0]};
    end
    pmax = (op == fcvt_pkg::cvt64) ? 64'h7fff_ffff_ffff_ffff : 64'h0000_0000_7fff_ffff;
    nmin = (op == fcvt_pkg::cvt64) ? 64'h8000_0000_0000_0000 : 64'hffff_ffff_8000_0000;
    lim  = (op == fcvt_pkg::cvt64) ? (128'd1 << 63) : (128'd1 << 31);
    if (op == fcvt_pkg::raw) return {2'b00, word};
    if (exp_max && frac_nz) return {inv, pmax};  // NaN ignores the sign.
    if (exp_max || e >= 64) return {inv, sign ? nmin : pmax};
    if (exp_zero) return {frac_nz ? inx : 2'b00, 64'd0};
    if (e >= fbits) begin
      mag  = m << (e - fbits);
      lost = 1'b0;
    end else if (e >= 0) begin
      mag  = m >> (fbits - e);
      lost = |(m & ((128'd1 << (fbits - e)) - 128'd1));
    end else begin
      mag  = '0;
      lost = 1'b1;  // Magnitude below one.
    end
    if (sign ? (mag > lim) : (mag > lim - 128'd1)) return {inv, sign ? nmin : pmax};
    return {lost ? inx : 2'b00, sign ? -mag[63:0] : mag[63:0]};
  endfunction

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1.
  endfunction

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v          = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Packed as {double, single}. Order: +0, -0, denormal, +inf, -inf, qNaN,
  // int32 max region, int32 min, int64 max region, int64 min, -0.5.
  function automatic logic [95:0] special_word(int idx);
    case (idx)
      0:       return {64'h0000_0000_0000_0000, 32'h0000_0000};
      1:       return {64'h8000_0000_0000_0000, 32'h8000_0000};
      2:       return {64'h0008_0000_0000_0000, 32'h0040_0000};
      3:       return {64'h7ff0_0000_0000_0000, 32'h7f80_0000};
      4:       return {64'hfff0_0000_0000_0000, 32'hff80_0000};
      5:       return {64'h7ff8_0000_0000_0000, 32'h7fc0_0000};
      6:       return {64'h41df_ffff_ffc0_0000, 32'h4eff_ffff};
      7:       return {64'hc1e0_0000_0000_0000, 32'hcf00_0000};
      8:       return {64'h43df_ffff_ffff_ffff, 32'h5eff_ffff};
      9:       return {64'hc3e0_0000_0000_0000, 32'hdf00_0000};
      default: return {64'hbfe0_0000_0000_0000, 32'hbf00_0000};
    endcase
  endfunction

  task automatic queue_op(input fcvt_pkg::fcvt_op_e op, input logic fmt, input logic [63:0] word);
    send_op.push_back(op);
    send_fmt.push_back(fmt);
    send_word.push_back(word);
  endtask

  // Exponents straddle the integer range of each format.
  task automatic queue_random_cvt(input logic fmt);
    logic [63:0] sel;
    logic [63:0] sign;
    logic [63:0] expo;
    logic [63:0] frac;
    sel  = rand_bits(1);
    sign = rand_bits(1);
    if (fmt == fcvt_pkg::fmt_dbl) begin
      expo = rand_bits(7);
      frac = rand_bits(52);
      queue_op(sel[0] ? fcvt_pkg::cvt64 : fcvt_pkg::cvt32, fmt,
               {sign[0], 11'(1015 + expo), frac[51:0]});
    end else begin
      expo = rand_bits(6);
      frac = rand_bits(23);
      queue_op(sel[0] ? fcvt_pkg::cvt64 : fcvt_pkg::cvt32, fmt,
               {32'b0, sign[0], 8'(100 + expo), frac[22:0]});
    end
  endtask

  task automatic wait_drained();
    while (send_op.size() != 0 || exp_value.size() != 0) @(posedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Producer, consumer and compare processes
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (in_credit) begin
      credits++;
      if (credits > depth) begin
        protocol_errors++;
        $display("unit granted more input credits than it has buffer entries in %s", test_name);
      end
    end
    if (credits > 0 && send_op.size() != 0) begin
      ref_res = fcvt_ref(send_op[0], send_fmt[0], send_word[0]);
      exp_value.push_back(ref_res[63:0]);
      exp_flags.push_back(ref_res[65:64]);
      exp_tag.push_back(next_tag);
      in_valid <= 1'b1;
      in_op    <= send_op.pop_front();
      in_fmt   <= send_fmt.pop_front();
      in_word  <= send_word.pop_front();
      in_tag   <= next_tag;
      next_tag++;
      credits--;
      ops_sent++;
    end else begin
      in_valid <= 1'b0;
    end
  end

  // Outstanding credits never exceed what the unit's counter can hold.
  always @(negedge clk) begin
    if (res_valid) res_taken++;
    if (policy == pol_free && credit_issued - res_taken < res_credits) begin
      res_credit <= 1'b1;
      credit_issued++;
    end else if (policy == pol_single && credit_issued == res_taken) begin
      res_credit <= 1'b1;  // One credit at a time.
      credit_issued++;
    end else begin
      res_credit <= 1'b0;
    end
  end

  always @(negedge clk) begin
    if (res_credit) res_granted++;  // Grant driven on the previous falling edge.
    if (res_valid) begin
      results_seen++;
      if (results_seen > res_granted) begin
        protocol_errors++;
        $display("result sent without a result credit in %s", test_name);
      end
      if (exp_value.size() == 0) begin
        protocol_errors++;
        $display("result arrived with no operation outstanding in %s", test_name);
      end else begin
        want_value = exp_value.pop_front();
        want_flags = exp_flags.pop_front();
        want_tag   = exp_tag.pop_front();
        if (res_value !== want_value) begin
          value_errors++;
          $display("error %s value: expected %h, actual %h", test_name, want_value, res_value);
        end
        if (res_flags !== want_flags) begin
          flag_errors++;
          $display("error %s flags: expected %b, actual %b", test_name, want_flags, res_flags);
        end
        if (res_tag !== want_tag) begin
          tag_errors++;
          $display("error %s tag: expected %h, actual %h", test_name, want_tag, res_tag);
        end
      end
    end
  end

  initial begin
    repeat (total_ops * 40 + 200) @(posedge clk);
    $display("timeout with %0d results still outstanding", exp_value.size() + send_op.size());
    $display("TESTBENCH FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [95:0] pair;
    logic [63:0] w;
    logic [63:0] f;
    reset      = 1'b1;
    in_valid   = 1'b0;
    in_op      = fcvt_pkg::cvt32;
    in_fmt     = 1'b0;
    in_word    = '0;
    in_tag     = '0;
    res_credit = 1'b0;
    next_tag   = '0;
    lfsr_state = 32'hd723;
    policy     = pol_hold;
    test_name  = "credit_grant";
    repeat (4) @(negedge clk);
    reset = 1'b0;
    repeat (depth + 6) @(posedge clk);
    if (credits != depth) begin
      protocol_errors++;
      $display("error %s credits: expected %0d, actual %0d", test_name, depth, credits);
    end

    test_name = "single_random";
    policy    = pol_free;
    for (int i = 0; i < n_rand; i++) queue_random_cvt(fcvt_pkg::fmt_sng);
    wait_drained();

    test_name = "double_random";
    for (int i = 0; i < n_rand; i++) queue_random_cvt(fcvt_pkg::fmt_dbl);
    wait_drained();

    test_name = "special_cases";
    for (int i = 0; i < n_special / 4; i++) begin
      pair = special_word(i);
      queue_op(fcvt_pkg::cvt32, fcvt_pkg::fmt_sng, {32'b0, pair[31:0]});
      queue_op(fcvt_pkg::cvt64, fcvt_pkg::fmt_sng, {32'b0, pair[31:0]});
      queue_op(fcvt_pkg::cvt32, fcvt_pkg::fmt_dbl, pair[95:32]);
      queue_op(fcvt_pkg::cvt64, fcvt_pkg::fmt_dbl, pair[95:32]);
    end
    wait_drained();

    test_name = "raw_move";
    for (int i = 0; i < n_raw; i++) begin
      w = rand_bits(64);
      f = rand_bits(1);
      queue_op(fcvt_pkg::raw, f[0], w);
    end
    wait_drained();

    test_name = "back_pressure";
    policy    = pol_hold;
    for (int i = 0; i < n_bp; i++) queue_random_cvt(fcvt_pkg::fmt_dbl);
    repeat (40) @(posedge clk);
    if (ops_sent - results_seen != depth + 2) begin  // Buffer plus both stages.
      protocol_errors++;
      $display("error %s in flight: expected %0d, actual %0d", test_name, depth + 2,
               ops_sent - results_seen);
    end
    policy = pol_single;
    wait_drained();
    repeat (4) @(posedge clk);
    if (credits != depth) begin
      protocol_errors++;
      $display("error %s returned credits: expected %0d, actual %0d", test_name, depth, credits);
    end

    $display("errors: value %0d, flags %0d, tag %0d, protocol %0d", value_errors, flag_errors,
             tag_errors, protocol_errors);
    if (value_errors + flag_errors + tag_errors + protocol_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
fcvt_pkg.sv
fcvt_in_fifo.sv
fcvt_classify.sv
fcvt_shift_sat.sv
fcvt_credit_counter.sv
fcvt_seq.sv
fcvt_top.sv
tb_fcvt_top.sv

// ==== Bender.yml ====
package:
  name: fcvt

sources:
  - fcvt_pkg.sv
  - fcvt_in_fifo.sv
  - fcvt_classify.sv
  - fcvt_shift_sat.sv
  - fcvt_credit_counter.sv
  - fcvt_seq.sv
  - fcvt_top.sv
  - target: simulation
    files:
      - tb_fcvt_top.sv
